// ==== rtl/ccPkg.sv ====
package ccPkg;

	// One codec channel as delivered by the ADC path
	localparam int codecWidth = 24;

	// Mono sample handed to the analysis side
	localparam int sampleWidth = 16;

	// Amplitude meter shown on the LED bar
	localparam int meterWidth = 10;

	// Sample buffer between intake and envelope follower
	localparam int fifoDepth = 8;

	// Threshold level, 0 to 15
	localparam int levelWidth = 4;

	// IIR shift control for the envelope filter
	localparam int shiftWidth = 3;

	// Stereo frame read from the codec, left in the upper half
	typedef struct packed
	{
		logic signed [codecWidth-1:0] left;
		logic signed [codecWidth-1:0] right;
	} codecFrame_t;

	// Trimmed mono sample
	typedef logic signed [sampleWidth-1:0] sample_t;

	// Wishbone classic controls from the master
	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
	} wbMaster_t;

	// Wishbone classic reply from the slave
	// data only meaningful while ack is high
	typedef struct packed
	{
		logic ack;
		sample_t data;
	} wbSlave_t;

endpackage

// ==== rtl/sampleIntake.sv ====
module sampleIntake
(
	input logic CLOCK_50,
	input logic reset,
	input logic readReady,
	input ccPkg::codecFrame_t frame,
	output logic codecRead,
	input logic full,
	output logic push,
	output ccPkg::sample_t pushData,
	output logic [ccPkg::meterWidth-1:0] meter
);
	// Both channels summed with one guard bit
	logic signed [ccPkg::codecWidth:0] rawSum;

	// Upper bits of the sum used for the meter
	logic signed [ccPkg::meterWidth-1:0] meterSlice;
	logic [ccPkg::meterWidth-1:0] meterAbs;

	always_comb
	begin
		rawSum = {frame.left[ccPkg::codecWidth-1], frame.left}
			+ {frame.right[ccPkg::codecWidth-1], frame.right};
	end

	// Take a frame only when the buffer has room
	assign codecRead = readReady && !full;

	// Each take becomes exactly one push
	assign push = codecRead;

	// Keep bits 23..8 for the analysis path
	assign pushData = rawSum[ccPkg::codecWidth-1:ccPkg::codecWidth-ccPkg::sampleWidth];

	assign meterSlice = rawSum[ccPkg::codecWidth-1:ccPkg::codecWidth-ccPkg::meterWidth];

	// Most negative slice comes out as 512, which still fits unsigned
	always_comb
	begin
		if (meterSlice[ccPkg::meterWidth-1])
			meterAbs = -meterSlice;
		else
			meterAbs = meterSlice;
	end

	// Meter follows the last frame taken
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
			meter <= '0;
		else if (codecRead)
			meter <= meterAbs;
	end

endmodule

// ==== rtl/sampleFifo.sv ====
module sampleFifo
(
	input logic CLOCK_50,
	input logic reset,
	input logic push,
	input ccPkg::sample_t pushData,
	output logic full,
	input ccPkg::wbMaster_t wbIn,
	output ccPkg::wbSlave_t wbOut
);
	localparam int ptrWidth = $clog2(ccPkg::fifoDepth);
	localparam int countWidth = ptrWidth + 1;

	ccPkg::sample_t mem [ccPkg::fifoDepth];

	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [countWidth-1:0] count;

	logic ack;
	logic request;
	logic doWrite;
	logic doPop;

	assign full = (count == countWidth'(ccPkg::fifoDepth));

	// Read request from the master, writes are never acknowledged
	assign request = wbIn.cyc && wbIn.stb && !wbIn.we;

	assign doWrite = push && !full;

	// Entry leaves the buffer at the edge that closes the transfer
	assign doPop = request && ack;

	// Ack one cycle after the request once there is data
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= request && !ack && (count != '0);
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (doWrite)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= (wrPtr == ptrWidth'(ccPkg::fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == ptrWidth'(ccPkg::fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			// Simultaneous push and pop cancel out
			if (doWrite && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doWrite)
				count <= count - 1'b1;
		end
	end

	// Bus data is zero outside the ack cycle
	always_comb
	begin
		wbOut.ack = ack;
		if (ack)
			wbOut.data = mem[rdPtr];
		else
			wbOut.data = '0;
	end

endmodule

// ==== rtl/envelopeFollower.sv ====
module envelopeFollower
(
	input logic CLOCK_50,
	input logic reset,
	input logic run,
	input logic [ccPkg::shiftWidth-1:0] iirShift,
	input ccPkg::sample_t threshold,
	output ccPkg::wbMaster_t wbOut,
	input ccPkg::wbSlave_t wbIn,
	output ccPkg::sample_t envelope,
	output logic peak
);
	// Read request in flight
	logic busy;
	logic done;

	ccPkg::sample_t sampleAbs;
	ccPkg::sample_t envNext;

	// One extra bit so the difference never wraps
	logic signed [ccPkg::sampleWidth:0] diff;
	logic signed [ccPkg::sampleWidth:0] step;

	assign done = busy && wbIn.ack;

	// Single reads with a one cycle gap after every ack
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
			busy <= 1'b0;
		else if (done)
			busy <= 1'b0;
		else if (!busy && run)
			busy <= 1'b1;
	end

	always_comb
	begin
		wbOut.cyc = busy;
		wbOut.stb = busy;
		wbOut.we = 1'b0;
	end

	// Absolute value, most negative input clamps to full scale
	always_comb
	begin
		if (wbIn.data == {1'b1, {(ccPkg::sampleWidth-1){1'b0}}})
			sampleAbs = {1'b0, {(ccPkg::sampleWidth-1){1'b1}}};
		else if (wbIn.data[ccPkg::sampleWidth-1])
			sampleAbs = -wbIn.data;
		else
			sampleAbs = wbIn.data;
	end

	// First order IIR, env += (|x| - env) >>> k
	always_comb
	begin
		diff = {sampleAbs[ccPkg::sampleWidth-1], sampleAbs}
			- {envelope[ccPkg::sampleWidth-1], envelope};
		step = diff >>> iirShift;
		envNext = envelope + step[ccPkg::sampleWidth-1:0];
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			envelope <= '0;
			peak <= 1'b0;
		end
		else if (done)
		begin
			envelope <= envNext;
			// Compare against the value being stored, not the old one
			peak <= envNext > threshold;
		end
	end

endmodule

// ==== rtl/thresholdSelect.sv ====
module thresholdSelect
(
	input logic CLOCK_50,
	input logic reset,
	input logic buttonUp,
	input logic buttonDown,
	output logic [ccPkg::levelWidth-1:0] level,
	output ccPkg::sample_t threshold
);
	logic upLast;
	logic downLast;

	// Registered rising edge pulses
	logic upEdge;
	logic downEdge;

	logic [ccPkg::sampleWidth-1:0] levelBit;

	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			upLast <= 1'b0;
			downLast <= 1'b0;
			upEdge <= 1'b0;
			downEdge <= 1'b0;
		end
		else
		begin
			upLast <= buttonUp;
			downLast <= buttonDown;
			upEdge <= buttonUp && !upLast;
			downEdge <= buttonDown && !downLast;
		end
	end

	// Saturating step, up has priority
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
			level <= '0;
		else if (upEdge && level != '1)
			level <= level + 1'b1;
		else if (downEdge && !upEdge && level != '0)
			level <= level - 1'b1;
	end

	// threshold = 2^level - 1
	always_comb
	begin
		levelBit = '0;
		levelBit[level] = 1'b1;
		threshold = levelBit - 1'b1;
	end

endmodule

// ==== rtl/colorChordFrontEnd.sv ====
module colorChordFrontEnd
(
	input logic CLOCK_50,
	input logic reset,

	// Codec read handshake
	input logic readReady,
	input ccPkg::codecFrame_t frame,
	output logic codecRead,

	// Analysis controls
	input logic run,
	input logic [ccPkg::shiftWidth-1:0] iirShift,
	input logic buttonUp,
	input logic buttonDown,

	// Board outputs
	output logic [ccPkg::meterWidth-1:0] meter,
	output logic [ccPkg::levelWidth-1:0] level,
	output ccPkg::sample_t envelope,
	output logic peak
);
	logic push;
	logic full;
	ccPkg::sample_t pushData;

	ccPkg::wbMaster_t wbReq;
	ccPkg::wbSlave_t wbRsp;

	ccPkg::sample_t threshold;

	sampleIntake intake_i
	(
		.CLOCK_50,
		.reset,
		.readReady,
		.frame,
		.codecRead,
		.full,
		.push,
		.pushData,
		.meter
	);

	sampleFifo fifo_i
	(
		.CLOCK_50,
		.reset,
		.push,
		.pushData,
		.full,
		.wbIn(wbReq),
		.wbOut(wbRsp)
	);

	envelopeFollower follower_i
	(
		.CLOCK_50,
		.reset,
		.run,
		.iirShift,
		.threshold,
		.wbOut(wbReq),
		.wbIn(wbRsp),
		.envelope,
		.peak
	);

	// Buttons step the detection threshold
	thresholdSelect thresh_i
	(
		.CLOCK_50,
		.reset,
		.buttonUp,
		.buttonDown,
		.level,
		.threshold
	);

endmodule

// ==== tb/tbColorChordFrontEnd.sv ====
module tbColorChordFrontEnd;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int numRows = 25;
	// First row filled from the random generator
	localparam int firstRandom = 12;
	// Rows taken with run low until the FIFO is full
	localparam int firstHeld = 16;
	localparam int heldRow = numRows - 1;
	localparam int cycleLimit = 40 * numRows + 100;

	typedef struct packed
	{
		logic signed [ccPkg::codecWidth-1:0] left;
		logic signed [ccPkg::codecWidth-1:0] right;
		logic [ccPkg::shiftWidth-1:0] shift;
		logic run;
		// Up presses when positive and down presses when negative
		int buttons;
		logic [ccPkg::meterWidth-1:0] expMeter;
		ccPkg::sample_t expEnv;
		logic [ccPkg::levelWidth-1:0] expLevel;
		logic expPeak;
	} row_t;

	logic CLOCK_50;
	logic reset;
	logic readReady;
	ccPkg::codecFrame_t frame;
	logic codecRead;
	logic run;
	logic [ccPkg::shiftWidth-1:0] iirShift;
	logic buttonUp;
	logic buttonDown;
	logic [ccPkg::meterWidth-1:0] meter;
	logic [ccPkg::levelWidth-1:0] level;
	ccPkg::sample_t envelope;
	logic peak;

	row_t rowTable [numRows];
	int cycleCount;
	int pressLevel;
	ccPkg::sample_t lastEnv;

	colorChordFrontEnd dut_i
	(
		.CLOCK_50,
		.reset,
		.readReady,
		.frame,
		.codecRead,
		.run,
		.iirShift,
		.buttonUp,
		.buttonDown,
		.meter,
		.level,
		.envelope,
		.peak
	);

	always #4 CLOCK_50 = ~CLOCK_50;

	task automatic stopOnFailure(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "Stopping on first error");
	endtask

	// Guards against a stalled handshake
	always @(posedge CLOCK_50)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
			stopOnFailure("Run timed out waiting for a take or an envelope update");
	end

	task automatic checkSample(input string name, input ccPkg::sample_t got,
		input ccPkg::sample_t exp);
		if (got !== exp)
			stopOnFailure($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic checkMeter(input logic [ccPkg::meterWidth-1:0] got,
		input logic [ccPkg::meterWidth-1:0] exp);
		if (got !== exp)
			stopOnFailure($sformatf("Error: meter is 0x%h, expected 0x%h", got, exp));
	endtask

	task automatic checkLevel(input logic [ccPkg::levelWidth-1:0] got,
		input logic [ccPkg::levelWidth-1:0] exp);
		if (got !== exp)
			stopOnFailure($sformatf("Error: level is 0x%h, expected 0x%h", got, exp));
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stopOnFailure($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Bits 23 down to 8 of the channel sum
	function automatic ccPkg::sample_t trimSum(input logic signed [23:0] l,
		input logic signed [23:0] r);
		logic signed [24:0] s;
		s = 25'(l) + 25'(r);
		return s[23:8];
	endfunction

	function automatic ccPkg::sample_t absSample(input ccPkg::sample_t x);
		int v;
		v = int'(x);
		if (v < 0)
			v = -v;
		if (v > 32767)
			v = 32767;
		return ccPkg::sample_t'(v);
	endfunction

	function automatic ccPkg::sample_t iirNext(input ccPkg::sample_t env,
		input ccPkg::sample_t x, input logic [ccPkg::shiftWidth-1:0] sh);
		int d;
		d = int'(absSample(x)) - int'(env);
		d = d >>> sh;
		return ccPkg::sample_t'(int'(env) + d);
	endfunction

	function automatic logic [ccPkg::meterWidth-1:0] meterOf(input logic signed [23:0] l,
		input logic signed [23:0] r);
		logic signed [24:0] s;
		logic signed [9:0] m;
		int v;
		s = 25'(l) + 25'(r);
		m = s[23:14];
		v = int'(m);
		if (v < 0)
			v = -v;
		return 10'(v);
	endfunction

	function automatic int stepLevel(input int lv, input bit up);
		if (up)
			return (lv < 15) ? lv + 1 : 15;
		return (lv > 0) ? lv - 1 : 0;
	endfunction

	task automatic setRow(input int i, input logic [23:0] l, input logic [23:0] r,
		input int sh, input int btn);
		rowTable[i].left = l;
		rowTable[i].right = r;
		rowTable[i].shift = 3'(sh);
		rowTable[i].run = 1'b1;
		rowTable[i].buttons = btn;
	endtask

	// Directed rows and random fill with expected values in update order
	task automatic buildTable;
		ccPkg::sample_t env;
		ccPkg::sample_t nextEnv;
		int lv;
		int n;
		setRow(0, 24'h100000, 24'h0ff000, 0, -1);
		// Sum overflows into the sign bit of the trimmed sample
		setRow(1, 24'h7fffff, 24'h7fffff, 0, 3);
		setRow(2, 24'h800000, 24'h000000, 0, 20);
		setRow(3, 24'h800000, 24'h800000, 0, -2);
		setRow(4, 24'h400000, 24'h400000, 0, 5);
		setRow(5, 24'h123456, 24'hfedcba, 0, -9);
		setRow(6, 24'h200000, 24'h000000, 2, -4);
		setRow(7, 24'h200000, 24'h000000, 2, 1);
		setRow(8, 24'hd00000, 24'h000000, 3, 2);
		setRow(9, 24'h000000, 24'h000000, 1, -1);
		setRow(10, 24'h7fffff, 24'h000000, 4, 0);
		setRow(11, 24'h010000, 24'h010000, 7, 0);
		env = '0;
		lv = 0;
		for (int i = 0; i < numRows; i++)
		begin
			if (i >= firstRandom)
			begin
				do
				begin
					setRow(i, 24'($urandom), 24'($urandom), int'($urandom % 4), 0);
					nextEnv = iirNext(env, trimSum(rowTable[i].left, rowTable[i].right),
						rowTable[i].shift);
				end
				while (nextEnv == env);
				rowTable[i].run = (i < firstHeld) ? 1'b1 : 1'b0;
			end
			n = (rowTable[i].buttons < 0) ? -rowTable[i].buttons : rowTable[i].buttons;
			for (int k = 0; k < n; k++)
				lv = stepLevel(lv, rowTable[i].buttons > 0);
			nextEnv = iirNext(env, trimSum(rowTable[i].left, rowTable[i].right),
				rowTable[i].shift);
			if (nextEnv == env)
				stopOnFailure($sformatf("Table row %0d leaves the envelope unchanged", i));
			env = nextEnv;
			rowTable[i].expMeter = meterOf(rowTable[i].left, rowTable[i].right);
			rowTable[i].expEnv = env;
			rowTable[i].expLevel = 4'(lv);
			rowTable[i].expPeak = int'(env) > ((1 << lv) - 1);
		end
	endtask

	// One button press with the level checked two cycles after the edge
	task automatic pulseButton(input bit up);
		if (up)
			buttonUp = 1'b1;
		else
			buttonDown = 1'b1;
		@(negedge CLOCK_50);
		buttonUp = 1'b0;
		buttonDown = 1'b0;
		// Only the edge has been captured so far
		checkLevel(level, 4'(pressLevel));
		@(negedge CLOCK_50);
		pressLevel = stepLevel(pressLevel, up);
		checkLevel(level, 4'(pressLevel));
	endtask

	// Codec model holds the frame until it is taken and then checks the meter
	task automatic takeFrame(input int i);
		frame.left = rowTable[i].left;
		frame.right = rowTable[i].right;
		readReady = 1'b1;
		forever
		begin
			#1;
			if (codecRead)
				break;
			@(negedge CLOCK_50);
		end
		@(negedge CLOCK_50);
		readReady = 1'b0;
		checkMeter(meter, rowTable[i].expMeter);
	endtask

	// Next envelope change belongs to row i
	task automatic awaitEnvelope(input int i);
		while (envelope == lastEnv)
			@(negedge CLOCK_50);
		checkSample("envelope", envelope, rowTable[i].expEnv);
		checkFlag("peak", peak, rowTable[i].expPeak);
		lastEnv = envelope;
	endtask

	initial
	begin
		CLOCK_50 = 1'b0;
		reset = 1'b1;
		readReady = 1'b0;
		frame = '0;
		run = 1'b0;
		iirShift = '0;
		buttonUp = 1'b0;
		buttonDown = 1'b0;
		cycleCount = 0;
		pressLevel = 0;
		lastEnv = '0;
		void'($urandom(8460));
		buildTable();

		repeat (2) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		reset = 1'b0;
		checkSample("envelope", envelope, '0);
		checkMeter(meter, '0);
		checkLevel(level, '0);
		checkFlag("peak", peak, 1'b0);
		checkFlag("codecRead", codecRead, 1'b0);

		// Free-running rows with one update per take
		for (int i = 0; i < firstHeld; i++)
		begin
			for (int k = 0; k < rowTable[i].buttons; k++)
				pulseButton(1'b1);
			for (int k = 0; k < -rowTable[i].buttons; k++)
				pulseButton(1'b0);
			checkLevel(level, rowTable[i].expLevel);
			iirShift = rowTable[i].shift;
			run = rowTable[i].run;
			takeFrame(i);
			awaitEnvelope(i);
		end

		// Back-pressure with the consumer stopped
		run = rowTable[firstHeld].run;
		for (int i = firstHeld; i < heldRow; i++)
			takeFrame(i);
		frame.left = rowTable[heldRow].left;
		frame.right = rowTable[heldRow].right;
		readReady = 1'b1;
		repeat (10)
		begin
			#1;
			if (codecRead)
				stopOnFailure("Codec frame taken while the FIFO was full");
			@(negedge CLOCK_50);
		end

		run = 1'b1;
		fork
			takeFrame(heldRow);
			for (int i = firstHeld; i < numRows; i++)
			begin
				iirShift = rowTable[i].shift;
				awaitEnvelope(i);
			end
		join

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== tb.f ====
rtl/ccPkg.sv
rtl/sampleIntake.sv
rtl/sampleFifo.sv
rtl/envelopeFollower.sv
rtl/thresholdSelect.sv
rtl/colorChordFrontEnd.sv
tb/tbColorChordFrontEnd.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbColorChordFrontEnd
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
